// ==== sim/rvx_trace.txt ====
# op adr data : op is W (write) or R (read), adr is the hex word address
# data is hex write data on W lines and the expected read value on R lines
R 01 0
W 21 5
W 22 FFFFFFFFFFFFFFF0
W 20 123
R 20 0
# addi slti sltiu andi ori xori slli srli srai
W 00 FFD08193
R 23 2
W 00 00112213
R 24 1
W 00 00113293
R 25 0
W 00 0FF17313
R 26 F0
W 00 0A00E393
R 27 A5
W 00 FFF14413
R 28 F
W 00 02809493
R 29 0000050000000000
W 00 03C15513
R 2A F
W 00 40215593
R 2B FFFFFFFFFFFFFFFC
R 01 24
# mul mulh mulhsu mulhu sub sra
W 00 02110733
R 2E FFFFFFFFFFFFFFB0
W 00 021117B3
R 2F FFFFFFFFFFFFFFFF
W 00 02212833
R 30 FFFFFFFFFFFFFFF0
W 00 021138B3
R 31 4
W 00 40208933
R 32 15
W 00 401159B3
R 33 FFFFFFFFFFFFFFFF
# W forms around the 32-bit boundary
W 2C 7FFFFFFF
W 2D 1
W 00 00D60A3B
R 34 FFFFFFFF80000000
W 00 40C68ABB
R 35 FFFFFFFF80000002
W 00 00C69B3B
R 36 FFFFFFFF80000000
W 00 00115BBB
R 37 7FFFFFF
W 00 40DB5C3B
R 38 FFFFFFFFC0000000
R 01 50
# lui auipc jal jalr
W 01 1000
W 00 12345CB7
R 39 12345000
R 01 1004
W 00 FFFFFD17
R 3A 4
R 01 1008
W 00 10000DEF
R 3B 100C
R 01 1108
W 00 03008E67
R 3C 110C
R 01 34
# Branches, taken then not taken, offset +16
W 01 200
W 00 00108863
R 02 2
W 00 00208863
R 02 0
R 01 214
W 00 00209863
R 02 2
W 00 00109863
R 02 0
R 01 228
W 00 00114863
R 02 2
W 00 0020C863
R 02 0
R 01 23C
W 00 0020D863
R 02 2
W 00 00115863
R 02 0
R 01 250
W 00 0020E863
R 02 2
W 00 00116863
R 02 0
R 01 264
W 00 00117863
R 02 2
W 00 0020F863
R 02 0
R 01 278
# ld, sd, div and an all-zero word
W 00 0000B183
R 23 2
R 02 10000
W 00 00113023
R 02 20000
W 00 0220C1B3
R 23 2
R 02 30000
W 00 00000000
R 02 40000
R 01 278
W 02 0
R 02 0
# ebreak, then addi x3,x3,1 while halted and after clearing
W 00 00100073
R 02 1
R 01 278
W 00 00118193
R 23 2
R 01 278
W 02 0
R 02 0
W 00 00118193
R 23 3
R 01 27C

// ==== rvx_exec.f ====
hw/rvx_pkg.sv
hw/rvx_decoder.sv
hw/rvx_regfile.sv
hw/rvx_execute.sv
hw/rvx_ctrl_regs.sv
hw/rvx_exec_top.sv
sim/tb_rvx_exec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f rvx_exec.f --top-module tb_rvx_exec -o sim_rvx_exec
out=$(./obj_dir/sim_rvx_exec)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

// ==== sim/tb_rvx_exec.sv ====
// RV64IM execute unit testbench
`timescale 1ns/1ns

module tb_rvx_exec;

  logic             clk;
  logic             rst_n;
  rvx_pkg::wb_m2s_t wb_in;
  rvx_pkg::wb_s2m_t wb_out;

  int   check_errs = 0;
  int   bus_errs   = 0;
  int   file_errs  = 0;
  int   cycle_cnt  = 0;
  int   cycle_limit = 0;
  logic bus_hung   = 1'b0;

  rvx_exec_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_in  (wb_in),
    .wb_out (wb_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // One Wishbone classic access with data sampled on the falling edge
  task automatic bus_access(input logic we, input logic [5:0] adr,
                            input logic [63:0] wdat, output logic [63:0] rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(posedge clk);
    #2;
    wb_in.cyc = 1'b1;
    wb_in.stb = 1'b1;
    wb_in.we  = we;
    wb_in.adr = adr;
    wb_in.dat = wdat;
    @(negedge clk);
    while (!wb_out.ack && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (wb_out.ack) begin
      rdat = wb_out.dat;
      // Ack belongs in the second cycle after stb rises
      assert (waited == 2) else begin
        $display("CHECK FAILED at %0t: addr %h ack after %0d cycles, expected 2",
                 $time, adr, waited);
        check_errs++;
      end
    end else begin
      $display("Bus hang: no ack from address %h within 10 cycles", adr);
      bus_errs++;
      bus_hung = 1'b1;
    end
    @(posedge clk);
    #2;
    wb_in = '0;  // Drop stb after the ack
  endtask

  task automatic wb_write(input logic [5:0] adr, input logic [63:0] wdat);
    logic [63:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [5:0] adr, input logic [63:0] exp);
    logic [63:0] got;
    bus_access(1'b0, adr, '0, got);
    if (!bus_hung) begin
      assert (got === exp) else begin
        $display("CHECK FAILED at %0t: addr %h expected %h got %h", $time, adr, exp, got);
        check_errs++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: run went past %0d cycles", cycle_limit);
      $display("Errors: check=%0d bus=%0d file=%0d timeout=1", check_errs, bus_errs,
               file_errs);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    int          fd;
    int          n_ops;
    int          code;
    string       line;
    byte         op;
    logic [5:0]  adr;
    logic [63:0] dat;
    wb_in = '0;
    rst_n = 1'b0;
    n_ops = 0;
    fd = $fopen("sim/rvx_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open trace file sim/rvx_trace.txt");
      file_errs++;
    end else begin
      // First pass sizes the timeout
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line[0] != "#") n_ops++;
      end
      $fclose(fd);
      cycle_limit = n_ops * 12 + 100;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      fd = $fopen("sim/rvx_trace.txt", "r");
      while (!$feof(fd) && !bus_hung) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%c %h %h", op, adr, dat);
          if (code != 3) begin
            $display("Unreadable trace line: %s", line);
            file_errs++;
          end else if (op == "W") begin
            wb_write(adr, dat);
          end else if (op == "R") begin
            wb_read(adr, dat);
          end else begin
            $display("Unknown trace operation in line: %s", line);
            file_errs++;
          end
        end
      end
      $fclose(fd);
    end
    $display("Errors: check=%0d bus=%0d file=%0d timeout=0", check_errs, bus_errs,
             file_errs);
    if (check_errs + bus_errs + file_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== hw/rvx_exec_top.sv ====
// RV64IM bus-issued execute unit
`timescale 1ns/1ns

module rvx_exec_top (
  input  logic             clk,
  input  logic             rst_n,
  input  rvx_pkg::wb_m2s_t wb_in,
  output rvx_pkg::wb_s2m_t wb_out
);

  logic [rvx_pkg::inst_width-1:0]   inst;
  logic [rvx_pkg::xlen-1:0]         pc;
  rvx_pkg::dec_ctrl_t               ctrl;
  rvx_pkg::exec_res_t               res;
  logic [rvx_pkg::xlen-1:0]         rs1_data, rs2_data, dbg_data, wr_data;
  logic [rvx_pkg::reg_id_width-1:0] dbg_id, wr_id;
  logic                             wr_en;

  rvx_ctrl_regs u_ctrl_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_in    (wb_in),
    .wb_out   (wb_out),
    .inst     (inst),
    .pc       (pc),
    .ctrl     (ctrl),
    .res      (res),
    .dbg_id   (dbg_id),
    .dbg_data (dbg_data),
    .wr_en    (wr_en),
    .wr_id    (wr_id),
    .wr_data  (wr_data)
  );

  rvx_decoder u_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  rvx_regfile u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_id   (ctrl.rs1),
    .rs2_id   (ctrl.rs2),
    .dbg_id   (dbg_id),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_data (dbg_data),
    .wr_en    (wr_en),
    .wr_id    (wr_id),
    .wr_data  (wr_data)
  );

  rvx_execute u_execute (
    .ctrl     (ctrl),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .res      (res)
  );

endmodule

// ==== hw/rvx_ctrl_regs.sv ====
// Wishbone register block and retire control
`timescale 1ns/1ns

module rvx_ctrl_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  rvx_pkg::wb_m2s_t                   wb_in,
  output rvx_pkg::wb_s2m_t                   wb_out,
  output logic [rvx_pkg::inst_width-1:0]     inst,
  output logic [rvx_pkg::xlen-1:0]           pc,
  input  rvx_pkg::dec_ctrl_t                 ctrl,
  input  rvx_pkg::exec_res_t                 res,
  output logic [rvx_pkg::reg_id_width-1:0]   dbg_id,
  input  logic [rvx_pkg::xlen-1:0]           dbg_data,
  output logic                               wr_en,
  output logic [rvx_pkg::reg_id_width-1:0]   wr_id,
  output logic [rvx_pkg::xlen-1:0]           wr_data
);

  typedef enum logic [1:0] {st_idle, st_busy, st_ack} state_e;

  state_e              state;
  logic                req, start, retire_q, halted, taken, host_gpr_wr, retire_wen;
  logic [15:0]         illegal_cnt;
  rvx_pkg::reg_addr_e  adr;

  assign req   = wb_in.cyc & wb_in.stb;
  assign start = req && state == st_idle;
  assign adr   = rvx_pkg::reg_addr_e'(wb_in.adr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: if (req) state <= st_busy;
        st_busy: state <= req ? st_ack : st_idle;  // No ack once the master gives up
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst        <= '0;
      pc          <= '0;
      retire_q    <= 1'b0;
      halted      <= 1'b0;
      taken       <= 1'b0;
      illegal_cnt <= '0;
    end else begin
      retire_q <= 1'b0;
      if (start && wb_in.we) begin
        case (adr)
          rvx_pkg::adr_inst: begin
            inst     <= wb_in.dat[31:0];
            retire_q <= !halted;  // Dropped while halted
          end
          rvx_pkg::adr_pc: pc <= wb_in.dat;
          rvx_pkg::adr_status: begin
            halted      <= 1'b0;
            taken       <= 1'b0;
            illegal_cnt <= '0;
          end
          default: ;
        endcase
      end
      if (retire_q) begin
        if (ctrl.not_impl) begin
          illegal_cnt <= illegal_cnt + 16'd1;
        end else if (ctrl.is_ebreak) begin
          halted <= 1'b1;
        end else begin
          pc <= res.next_pc;
          if (ctrl.is_branch) taken <= res.taken;
        end
      end
    end
  end

  // Register write port shared by retire and host GPR writes
  assign host_gpr_wr = start && wb_in.we && wb_in.adr >= rvx_pkg::adr_gpr_base;
  assign retire_wen  = ctrl.reg_wen && !ctrl.not_impl && !ctrl.is_ebreak && ctrl.rd != '0;
  assign wr_en       = retire_q ? retire_wen : host_gpr_wr;
  assign wr_id       = retire_q ? ctrl.rd : wb_in.adr[4:0];
  assign wr_data     = retire_q ? res.rd_data : wb_in.dat;
  assign dbg_id      = wb_in.adr[4:0];

  assign wb_out.ack = (state == st_ack);

  always_comb begin
    case (adr)
      rvx_pkg::adr_inst:   wb_out.dat = {32'b0, inst};
      rvx_pkg::adr_pc:     wb_out.dat = pc;
      rvx_pkg::adr_status: wb_out.dat = {32'b0, illegal_cnt, 14'b0, taken, halted};
      default: wb_out.dat = (wb_in.adr >= rvx_pkg::adr_gpr_base) ? dbg_data : '0;
    endcase
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_out.ack |-> (wb_in.cyc && wb_in.stb));
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    wb_out.ack |=> !wb_out.ack);

endmodule

// ==== hw/rvx_execute.sv ====
// ALU, multiplier and next PC
`timescale 1ns/1ns

module rvx_execute (
  input  rvx_pkg::dec_ctrl_t        ctrl,
  input  logic [rvx_pkg::xlen-1:0]  rs1_data,
  input  logic [rvx_pkg::xlen-1:0]  rs2_data,
  input  logic [rvx_pkg::xlen-1:0]  pc,
  output rvx_pkg::exec_res_t        res
);

  logic [rvx_pkg::xlen-1:0] op_a, op_b, sum, alu_res, srl_src, sra_src, srl_res, sra_res;
  logic [5:0]               shamt;
  logic                     lt_s, lt_u, cmp, a_sext, b_sext;
  logic signed [64:0]       mul_a, mul_b;
  logic signed [129:0]      prod;

  assign op_a  = ctrl.is_auipc ? pc : rs1_data;
  assign op_b  = ctrl.need_imm ? ctrl.imm : rs2_data;
  assign sum   = op_a + op_b;
  assign shamt = ctrl.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];
  assign lt_s  = $signed(op_a) < $signed(op_b);
  assign lt_u  = op_a < op_b;

  // W shifts see only the low word of rs1
  assign srl_src = ctrl.word_op ? {32'b0, op_a[31:0]} : op_a;
  assign sra_src = ctrl.word_op ? {{32{op_a[31]}}, op_a[31:0]} : op_a;
  assign srl_res = srl_src >> shamt;
  assign sra_res = $signed(sra_src) >>> shamt;

  // One 65x65 signed multiplier covers all four products
  assign a_sext = (ctrl.alu_op == rvx_pkg::mulh || ctrl.alu_op == rvx_pkg::mulhsu) & op_a[63];
  assign b_sext = (ctrl.alu_op == rvx_pkg::mulh) & op_b[63];
  assign mul_a  = {a_sext, op_a};
  assign mul_b  = {b_sext, op_b};
  assign prod   = mul_a * mul_b;

  always_comb begin
    alu_res = '0;
    cmp     = 1'b0;
    case (ctrl.alu_op)
      rvx_pkg::add:      alu_res = sum;
      rvx_pkg::sub:      alu_res = op_a - op_b;
      rvx_pkg::slt:      alu_res = {63'b0, lt_s};
      rvx_pkg::sltu:     alu_res = {63'b0, lt_u};
      rvx_pkg::and_op:   alu_res = op_a & op_b;
      rvx_pkg::or_op:    alu_res = op_a | op_b;
      rvx_pkg::xor_op:   alu_res = op_a ^ op_b;
      rvx_pkg::sll:      alu_res = op_a << shamt;
      rvx_pkg::srl:      alu_res = srl_res;
      rvx_pkg::sra:      alu_res = sra_res;
      rvx_pkg::pass_imm: alu_res = op_b;
      rvx_pkg::beq:      cmp = (op_a == op_b);
      rvx_pkg::bne:      cmp = (op_a != op_b);
      rvx_pkg::blt:      cmp = lt_s;
      rvx_pkg::bge:      cmp = !lt_s;
      rvx_pkg::bltu:     cmp = lt_u;
      rvx_pkg::bgeu:     cmp = !lt_u;
      rvx_pkg::mul:      alu_res = prod[63:0];
      rvx_pkg::mulh, rvx_pkg::mulhsu, rvx_pkg::mulhu:
        alu_res = prod[127:64];
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    res.taken = cmp;
    if (ctrl.is_jal || ctrl.is_jalr)
      res.rd_data = pc + 64'd4;  // Link address
    else if (ctrl.word_op)
      res.rd_data = {{32{alu_res[31]}}, alu_res[31:0]};
    else
      res.rd_data = alu_res;
    if (ctrl.is_jalr)
      res.next_pc = {sum[63:1], 1'b0};
    else if (ctrl.is_jal || (ctrl.is_branch && cmp))
      res.next_pc = pc + ctrl.imm;
    else
      res.next_pc = pc + 64'd4;
  end

endmodule

// ==== hw/rvx_regfile.sv ====
// Integer register file
`timescale 1ns/1ns

module rvx_regfile (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [rvx_pkg::reg_id_width-1:0]   rs1_id,
  input  logic [rvx_pkg::reg_id_width-1:0]   rs2_id,
  input  logic [rvx_pkg::reg_id_width-1:0]   dbg_id,
  output logic [rvx_pkg::xlen-1:0]           rs1_data,
  output logic [rvx_pkg::xlen-1:0]           rs2_data,
  output logic [rvx_pkg::xlen-1:0]           dbg_data,
  input  logic                               wr_en,
  input  logic [rvx_pkg::reg_id_width-1:0]   wr_id,
  input  logic [rvx_pkg::xlen-1:0]           wr_data
);

  logic [rvx_pkg::xlen-1:0] regs [1:31];  // No storage behind x0

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wr_en && wr_id != '0) begin
      regs[wr_id] <= wr_data;
    end
  end

  assign rs1_data = (rs1_id == '0) ? '0 : regs[rs1_id];
  assign rs2_data = (rs2_id == '0) ? '0 : regs[rs2_id];
  assign dbg_data = (dbg_id == '0) ? '0 : regs[dbg_id];

  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en && wr_id == '0) |=> (dbg_id != '0 || dbg_data == '0));

endmodule

// ==== hw/rvx_decoder.sv ====
// RV64IM instruction decoder
`timescale 1ns/1ns

module rvx_decoder (
  input  logic [rvx_pkg::inst_width-1:0] inst,
  output rvx_pkg::dec_ctrl_t             ctrl
);

  rvx_pkg::opcode_e       opc;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [5:0]             shf;  // RV64 shift immediates use inst[31:26]
  logic [rvx_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opc    = rvx_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign shf    = inst[31:26];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl          = '0;
    ctrl.alu_op   = rvx_pkg::add;
    ctrl.rd       = inst[11:7];
    ctrl.rs1      = inst[19:15];
    ctrl.rs2      = inst[24:20];
    ctrl.not_impl = 1'b1;  // Cleared by every legal encoding below
    case (opc)
      rvx_pkg::op_imm, rvx_pkg::op_imm_32: begin
        ctrl.imm      = imm_i;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.word_op  = (opc == rvx_pkg::op_imm_32);
        ctrl.not_impl = 1'b0;
        case (funct3)
          3'b000: ctrl.alu_op = rvx_pkg::add;
          3'b001: begin
            ctrl.alu_op   = rvx_pkg::sll;
            ctrl.not_impl = ctrl.word_op ? (funct7 != 7'd0) : (shf != 6'd0);
          end
          3'b101: begin
            ctrl.alu_op   = inst[30] ? rvx_pkg::sra : rvx_pkg::srl;
            ctrl.not_impl = ctrl.word_op ? (funct7 != 7'd0 && funct7 != 7'b0100000)
                                         : (shf != 6'd0 && shf != 6'b010000);
          end
          3'b010: ctrl.alu_op = rvx_pkg::slt;
          3'b011: ctrl.alu_op = rvx_pkg::sltu;
          3'b100: ctrl.alu_op = rvx_pkg::xor_op;
          3'b110: ctrl.alu_op = rvx_pkg::or_op;
          default: ctrl.alu_op = rvx_pkg::and_op;
        endcase
        // No logic ops among the W immediates
        if (ctrl.word_op && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
          ctrl.not_impl = 1'b1;
      end
      rvx_pkg::op, rvx_pkg::op_32: begin
        ctrl.reg_wen = 1'b1;
        ctrl.word_op = (opc == rvx_pkg::op_32);
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: ctrl.alu_op = rvx_pkg::add;
          {7'b0100000, 3'b000}: ctrl.alu_op = rvx_pkg::sub;
          {7'b0000000, 3'b001}: ctrl.alu_op = rvx_pkg::sll;
          {7'b0000000, 3'b101}: ctrl.alu_op = rvx_pkg::srl;
          {7'b0100000, 3'b101}: ctrl.alu_op = rvx_pkg::sra;
          {7'b0000001, 3'b000}: ctrl.alu_op = rvx_pkg::mul;
          {7'b0000000, 3'b010}: ctrl.alu_op = rvx_pkg::slt;
          {7'b0000000, 3'b011}: ctrl.alu_op = rvx_pkg::sltu;
          {7'b0000000, 3'b100}: ctrl.alu_op = rvx_pkg::xor_op;
          {7'b0000000, 3'b110}: ctrl.alu_op = rvx_pkg::or_op;
          {7'b0000000, 3'b111}: ctrl.alu_op = rvx_pkg::and_op;
          {7'b0000001, 3'b001}: ctrl.alu_op = rvx_pkg::mulh;
          {7'b0000001, 3'b010}: ctrl.alu_op = rvx_pkg::mulhsu;
          {7'b0000001, 3'b011}: ctrl.alu_op = rvx_pkg::mulhu;
          default: ctrl.alu_op = rvx_pkg::add;  // div, rem and bad funct7
        endcase
        // The first six entries are the only ones with a W form
        ctrl.not_impl = ctrl.alu_op == rvx_pkg::add && {funct7, funct3} != 10'd0;
        if (ctrl.word_op && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101)
          ctrl.not_impl = 1'b1;
        if (ctrl.word_op && funct7 == 7'b0000001 && funct3 != 3'b000)
          ctrl.not_impl = 1'b1;
      end
      rvx_pkg::lui: begin
        ctrl.alu_op   = rvx_pkg::pass_imm;
        ctrl.imm      = imm_u;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.not_impl = 1'b0;
      end
      rvx_pkg::auipc: begin
        ctrl.imm      = imm_u;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.is_auipc = 1'b1;
        ctrl.not_impl = 1'b0;
      end
      rvx_pkg::jal: begin
        ctrl.imm      = imm_j;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.is_jal   = 1'b1;
        ctrl.not_impl = 1'b0;
      end
      rvx_pkg::jalr: begin
        ctrl.imm      = imm_i;
        ctrl.need_imm = 1'b1;
        ctrl.reg_wen  = 1'b1;
        ctrl.is_jalr  = 1'b1;
        ctrl.not_impl = (funct3 != 3'b000);
      end
      rvx_pkg::branch: begin
        ctrl.imm       = imm_b;  // Operands stay rs1 and rs2
        ctrl.is_branch = 1'b1;
        ctrl.not_impl  = (funct3 == 3'b010 || funct3 == 3'b011);
        case (funct3)
          3'b000:  ctrl.alu_op = rvx_pkg::beq;
          3'b001:  ctrl.alu_op = rvx_pkg::bne;
          3'b100:  ctrl.alu_op = rvx_pkg::blt;
          3'b101:  ctrl.alu_op = rvx_pkg::bge;
          3'b110:  ctrl.alu_op = rvx_pkg::bltu;
          default: ctrl.alu_op = rvx_pkg::bgeu;
        endcase
      end
      rvx_pkg::system: begin
        ctrl.is_ebreak = (inst == 32'h0010_0073);
        ctrl.not_impl  = !ctrl.is_ebreak;  // ecall and CSRs unsupported
      end
      rvx_pkg::load:  ctrl.imm = imm_i;  // Recognized, not implemented
      rvx_pkg::store: ctrl.imm = imm_s;
      default: ctrl.not_impl = 1'b1;
    endcase
  end

endmodule

// ==== hw/rvx_pkg.sv ====
// RV64IM execute unit shared types
package rvx_pkg;

  localparam int xlen         = 64;
  localparam int inst_width   = 32;
  localparam int reg_id_width = 5;
  localparam int wb_adr_width = 6;

  // Major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op_imm    = 7'b0010011,
    op        = 7'b0110011,
    op_imm_32 = 7'b0011011,
    op_32     = 7'b0111011,
    lui       = 7'b0110111,
    auipc     = 7'b0010111,
    jal       = 7'b1101111,
    jalr      = 7'b1100111,
    branch    = 7'b1100011,
    load      = 7'b0000011,
    store     = 7'b0100011,
    system    = 7'b1110011
  } opcode_e;

  typedef enum logic [4:0] {
    add, sub, slt, sltu, and_op, or_op, xor_op,
    sll, srl, sra,
    pass_imm,
    beq, bne, blt, bge, bltu, bgeu,  // Branch compares
    mul, mulh, mulhsu, mulhu
  } alu_op_e;

  typedef struct packed {
    alu_op_e                 alu_op;
    logic [xlen-1:0]         imm;     // Sign extended
    logic [reg_id_width-1:0] rd;
    logic [reg_id_width-1:0] rs1;
    logic [reg_id_width-1:0] rs2;
    logic                    need_imm;
    logic                    word_op; // W forms
    logic                    reg_wen;
    logic                    is_auipc;
    logic                    is_jal;
    logic                    is_jalr;
    logic                    is_branch;
    logic                    is_ebreak;
    logic                    not_impl;
  } dec_ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] rd_data;
    logic [xlen-1:0] next_pc;
    logic            taken;
  } exec_res_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [wb_adr_width-1:0] adr;
    logic [xlen-1:0]         dat;
  } wb_m2s_t;

  typedef struct packed {
    logic            ack;
    logic [xlen-1:0] dat;
  } wb_s2m_t;

  // GPR n sits at word address adr_gpr_base + n
  typedef enum logic [wb_adr_width-1:0] {
    adr_inst     = 6'd0,
    adr_pc       = 6'd1,
    adr_status   = 6'd2,
    adr_gpr_base = 6'd32
  } reg_addr_e;

endpackage
